/* common/redmule_pkg.sv */
// Shared widths, APB register map and pipeline opcodes for the MX vector engine.
// The APB data bus is fixed at 32 bits, so reg_beat carries at most four lanes.
// Result registers sit at reg_res_base + 4*lane and are word aligned.

package redmule_pkg;

  // Packed X element and weight width
  localparam int unsigned elem_w = 8;

  // Shared exponent field, shifts 0 to 7
  localparam int unsigned exp_w = 3;

  // Decoded element, signed, wide enough for -128 << 7
  localparam int unsigned dec_w = 16;

  // Accumulator and Z register width
  localparam int unsigned acc_w = 32;

  // APB bus widths
  localparam int unsigned apb_addr_w = 8;
  localparam int unsigned apb_data_w = 32;

  // Register offsets
  localparam logic [apb_addr_w-1:0] reg_ctrl     = 8'h00;
  localparam logic [apb_addr_w-1:0] reg_xexp     = 8'h04;
  localparam logic [apb_addr_w-1:0] reg_welem    = 8'h08;
  localparam logic [apb_addr_w-1:0] reg_beat     = 8'h0C;
  localparam logic [apb_addr_w-1:0] reg_status   = 8'h10;
  localparam logic [apb_addr_w-1:0] reg_res_base = 8'h20;

  // Ops travelling down the decoder, PE and collector stages
  typedef enum logic [1:0] {
    op_nop   = 2'd0,
    op_mac   = 2'd1,
    op_clear = 2'd2
  } op_e;

endpackage : redmule_pkg

/* engine/redmule_pe.sv */
// One lane: signed multiply of decoded X by the weight, accumulated modulo 2^32.
// ovf_o pulses for one cycle when a MAC leaves the signed 32-bit range.
// op_clear zeroes the accumulator; the op is passed on one cycle later.

`timescale 1ns/1ps

module redmule_pe
  import redmule_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  op_e               op_i,
  input  logic [dec_w-1:0]  xdec_i,
  input  logic [elem_w-1:0] welem_i,
  output op_e               op_o,
  output logic [acc_w-1:0]  acc_o,
  output logic              ovf_o
);

  logic signed [dec_w+elem_w-1:0] prod;
  logic signed [acc_w:0]          sum;
  logic signed [acc_w-1:0]        acc_q;
  logic                           ovf_q;
  op_e                            op_q;

  assign prod = $signed(xdec_i) * $signed(welem_i);
  // One guard bit, so the top two bits differ on overflow
  assign sum  = acc_q + prod;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
      ovf_q <= 1'b0;
      op_q  <= op_nop;
    end else begin
      op_q  <= op_i;
      ovf_q <= 1'b0;
      case (op_i)
        op_mac: begin
          acc_q <= sum[acc_w-1:0];
          ovf_q <= sum[acc_w] ^ sum[acc_w-1];
        end
        op_clear: acc_q <= '0;
        default:  acc_q <= acc_q;
      endcase
    end
  end

  assign op_o  = op_q;
  assign acc_o = acc_q;
  assign ovf_o = ovf_q;

endmodule : redmule_pe

/* engine/redmule_z_collector.sv */
// Collects lane accumulators into Z registers after every op.
// All lanes run in lockstep, so lane 0's op stands for the whole row.
// Sticky overflow bits are held until an op_clear reaches this stage.
// done_o pulses once per op, which lets the APB side count ops in flight.

`timescale 1ns/1ps

module redmule_z_collector
  import redmule_pkg::*;
#(
  parameter int unsigned num_lanes = 4
)(
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  op_e                             op_i,
  input  logic [num_lanes-1:0][acc_w-1:0] acc_i,
  input  logic [num_lanes-1:0]            ovf_i,
  output logic [num_lanes-1:0][acc_w-1:0] z_o,
  output logic [num_lanes-1:0]            sticky_o,
  output logic                            done_o
);

  logic [num_lanes-1:0][acc_w-1:0] z_q;
  logic [num_lanes-1:0]            sticky_q;
  logic                            done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      z_q    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (op_i != op_nop);
      if (op_i != op_nop) begin
        z_q <= acc_i;
      end
    end
  end

  // Overflow pulses only come with a MAC, so the clear can take priority
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sticky_q <= '0;
    end else if (op_i == op_clear) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= sticky_q | ovf_i;
    end
  end

  assign z_o      = z_q;
  assign sticky_o = sticky_q;
  assign done_o   = done_q;

endmodule : redmule_z_collector

/* hdl/redmule_mx_decoder.sv */
// MX decode stage: each signed 8-bit element is scaled by 2^xexp.
// The product of the largest magnitude element and shift 7 still fits in dec_w.
// Op, weight and decoded lanes are registered together as one stage.

`timescale 1ns/1ps

module redmule_mx_decoder
  import redmule_pkg::*;
#(
  parameter int unsigned num_lanes = 4
)(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  op_e                              op_i,
  input  logic [exp_w-1:0]                 xexp_i,
  input  logic [elem_w-1:0]                welem_i,
  input  logic [num_lanes-1:0][elem_w-1:0] beat_i,
  output op_e                              op_o,
  output logic [elem_w-1:0]                welem_o,
  output logic [num_lanes-1:0][dec_w-1:0]  xdec_o
);

  logic [num_lanes-1:0][dec_w-1:0] xdec_d;
  logic [num_lanes-1:0][dec_w-1:0] xdec_q;
  logic [elem_w-1:0]               welem_q;
  op_e                             op_q;

  // Sign extend, then shift by the shared exponent
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      xdec_d[i] = {{(dec_w-elem_w){beat_i[i][elem_w-1]}}, beat_i[i]} << xexp_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_q <= op_nop;
    end else begin
      op_q <= op_i;
    end
  end

  // Data path, meaningful only alongside a valid op
  always_ff @(posedge clk_i) begin
    xdec_q  <= xdec_d;
    welem_q <= welem_i;
  end

  assign op_o    = op_q;
  assign welem_o = welem_q;
  assign xdec_o  = xdec_q;

endmodule : redmule_mx_decoder

/* hdl/redmule_apb_regs.sv */
// APB slave with the engine's configuration registers and op issue.
// Writes never stall. A read stalls while any issued op has not reached the collector.
// Unmapped accesses end with pslverr; such writes are dropped and reads return zero.
// op_o is driven straight from the completing write, so it is valid for that cycle only.

`timescale 1ns/1ps

module redmule_apb_regs
  import redmule_pkg::*;
#(
  parameter int unsigned num_lanes = 4
)(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [apb_addr_w-1:0]            paddr_i,
  input  logic [apb_data_w-1:0]            pwdata_i,
  output logic [apb_data_w-1:0]            prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  logic [num_lanes-1:0][acc_w-1:0]  z_i,
  input  logic [num_lanes-1:0]             ovf_i,
  input  logic                             done_i,
  output op_e                              op_o,
  output logic [exp_w-1:0]                 xexp_o,
  output logic [elem_w-1:0]                welem_o,
  output logic [num_lanes-1:0][elem_w-1:0] beat_o
);

  // Enough headroom for the three pipeline stages
  localparam int unsigned cnt_w = 3;

  logic [exp_w-1:0]  xexp_q;
  logic [elem_w-1:0] welem_q;
  logic [cnt_w-1:0]  inflight_q;
  logic              addr_hit;
  logic              access;
  logic              wr_done;
  logic              issue;

  assign access  = psel_i && penable_i;
  // Writes always see pready high
  assign wr_done = access && pwrite_i && addr_hit;

  assign pready_o  = !(psel_i && !pwrite_i && (inflight_q != '0));
  assign pslverr_o = access && pready_o && !addr_hit;

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      reg_ctrl, reg_beat: prdata_o = '0;
      reg_xexp:           prdata_o = apb_data_w'(xexp_q);
      reg_welem:          prdata_o = apb_data_w'(welem_q);
      reg_status:         prdata_o = apb_data_w'(ovf_i);
      default: begin
        addr_hit = 1'b0;
        // Lane results, one word each
        for (int i = 0; i < num_lanes; i++) begin
          if (paddr_i == apb_addr_w'(reg_res_base + 4 * i)) begin
            addr_hit = 1'b1;
            prdata_o = z_i[i];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      xexp_q  <= '0;
      welem_q <= '0;
    end else if (wr_done) begin
      if (paddr_i == reg_xexp) begin
        xexp_q <= pwdata_i[exp_w-1:0];
      end
      if (paddr_i == reg_welem) begin
        welem_q <= pwdata_i[elem_w-1:0];
      end
    end
  end

  // Op issue on a completed beat or clear write
  always_comb begin
    op_o = op_nop;
    if (wr_done && paddr_i == reg_beat) begin
      op_o = op_mac;
    end else if (wr_done && paddr_i == reg_ctrl && pwdata_i[0]) begin
      op_o = op_clear;
    end
  end

  assign issue   = (op_o != op_nop);
  assign xexp_o  = xexp_q;
  assign welem_o = welem_q;

  // Lane i takes byte i of the beat word
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      beat_o[i] = pwdata_i[i*elem_w +: elem_w];
    end
  end

  // Ops issued minus done pulses from the collector
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inflight_q <= '0;
    end else if (issue && !done_i) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (!issue && done_i) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

endmodule : redmule_apb_regs

/* hdl/redmule_top.sv */
// MX vector engine top: APB slave, MX decoder, one PE per lane and a Z collector.
// num_lanes must be 1 to 4, since one reg_beat write carries four 8-bit elements.
// Results are readable three cycles after the issuing write completes.

`timescale 1ns/1ps

module redmule_top
  import redmule_pkg::*;
#(
  parameter int unsigned num_lanes = 4
)(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [apb_addr_w-1:0] paddr_i,
  input  logic [apb_data_w-1:0] pwdata_i,
  output logic [apb_data_w-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  // Issue stage outputs
  op_e                              issue_op;
  logic [exp_w-1:0]                 issue_xexp;
  logic [elem_w-1:0]                issue_welem;
  logic [num_lanes-1:0][elem_w-1:0] issue_beat;

  // Decoder stage outputs
  op_e                              dec_op;
  logic [elem_w-1:0]                dec_welem;
  logic [num_lanes-1:0][dec_w-1:0]  dec_x;

  // Lane outputs, lane 0 carries the op to the collector
  op_e                              lane_op [num_lanes];
  logic [num_lanes-1:0][acc_w-1:0]  lane_acc;
  logic [num_lanes-1:0]             lane_ovf;

  // Collector outputs
  logic [num_lanes-1:0][acc_w-1:0]  z_regs;
  logic [num_lanes-1:0]             z_sticky;
  logic                             z_done;

  redmule_apb_regs #(
    .num_lanes ( num_lanes )
  ) i_apb_regs (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .psel_i    ( psel_i      ),
    .penable_i ( penable_i   ),
    .pwrite_i  ( pwrite_i    ),
    .paddr_i   ( paddr_i     ),
    .pwdata_i  ( pwdata_i    ),
    .prdata_o  ( prdata_o    ),
    .pready_o  ( pready_o    ),
    .pslverr_o ( pslverr_o   ),
    .z_i       ( z_regs      ),
    .ovf_i     ( z_sticky    ),
    .done_i    ( z_done      ),
    .op_o      ( issue_op    ),
    .xexp_o    ( issue_xexp  ),
    .welem_o   ( issue_welem ),
    .beat_o    ( issue_beat  )
  );

  redmule_mx_decoder #(
    .num_lanes ( num_lanes )
  ) i_mx_decoder (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .op_i    ( issue_op    ),
    .xexp_i  ( issue_xexp  ),
    .welem_i ( issue_welem ),
    .beat_i  ( issue_beat  ),
    .op_o    ( dec_op      ),
    .welem_o ( dec_welem   ),
    .xdec_o  ( dec_x       )
  );

  for (genvar i = 0; i < num_lanes; i++) begin : gen_lanes
    redmule_pe i_pe (
      .clk_i   ( clk_i       ),
      .rst_n_i ( rst_n_i     ),
      .op_i    ( dec_op      ),
      .xdec_i  ( dec_x[i]    ),
      .welem_i ( dec_welem   ),
      .op_o    ( lane_op[i]  ),
      .acc_o   ( lane_acc[i] ),
      .ovf_o   ( lane_ovf[i] )
    );
  end

  redmule_z_collector #(
    .num_lanes ( num_lanes )
  ) i_z_collector (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .op_i     ( lane_op[0] ),
    .acc_i    ( lane_acc   ),
    .ovf_i    ( lane_ovf   ),
    .z_o      ( z_regs     ),
    .sticky_o ( z_sticky   ),
    .done_o   ( z_done     )
  );

endmodule : redmule_top

/* tests/redmule_tb_tasks.svh */
// APB driver tasks, reference model and directed tests for the MX engine testbench.
// Every task starts and returns 2 ns after a rising clock edge.
// The model keeps its own accumulators, overflow bits, weight and exponent.

`ifndef REDMULE_TB_TASKS_SVH
`define REDMULE_TB_TASKS_SVH

task automatic check_value(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
  assert (actual === expected) else begin
    error_count++;
    $display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
             test, what, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  end
endtask

// One APB transfer, setup then access phase until pready
task automatic apb_access(input logic write, input logic [apb_addr_w-1:0] addr,
                          input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  @(posedge clk);
  #(drive_delay);
  penable = 1'b1;
  @(negedge clk);
  while (!pready) @(negedge clk);
  rdata = prdata;
  err   = pslverr;
  @(posedge clk);
  #(drive_delay);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_write(input string test, input logic [apb_addr_w-1:0] addr,
                         input logic [31:0] data);
  logic [31:0] unused;
  logic        err;
  apb_access(1'b1, addr, data, unused, err);
  check_value(test, $sformatf("pslverr on write 0x%02h", addr), 32'd0, 32'(err));
endtask

task automatic apb_read(input string test, input logic [apb_addr_w-1:0] addr,
                        output logic [31:0] data);
  logic err;
  apb_access(1'b0, addr, 32'd0, data, err);
  check_value(test, $sformatf("pslverr on read 0x%02h", addr), 32'd0, 32'(err));
endtask

task automatic model_clear();
  for (int i = 0; i < num_lanes; i++) begin
    model_acc[i] = '0;
  end
  model_ovf = '0;
endtask

// Element times 2^exp times weight, added with a wide sum to spot overflow
task automatic model_mac(input logic [31:0] beat);
  longint decoded;
  longint sum;
  for (int i = 0; i < num_lanes; i++) begin
    decoded = longint'($signed(beat[i*elem_w +: elem_w])) * (longint'(2) ** model_exp);
    sum     = longint'(model_acc[i]) + decoded * longint'($signed(model_w));
    if (sum > 64'sd2147483647 || sum < -64'sd2147483648) begin
      model_ovf[i] = 1'b1;
    end
    model_acc[i] = 32'(sum);
  end
endtask

task automatic set_exp(input string test, input logic [exp_w-1:0] value);
  apb_write(test, reg_xexp, 32'(value));
  model_exp = value;
endtask

task automatic set_weight(input string test, input logic [elem_w-1:0] value);
  apb_write(test, reg_welem, 32'(value));
  model_w = value;
endtask

task automatic clear_engine(input string test);
  apb_write(test, reg_ctrl, 32'd1);
  model_clear();
endtask

task automatic mac_beat(input string test, input logic [31:0] beat);
  apb_write(test, reg_beat, beat);
  model_mac(beat);
endtask

// Compare every Z register and the status bits with the model
task automatic check_lanes(input string test);
  logic [31:0] data;
  for (int i = 0; i < num_lanes; i++) begin
    apb_read(test, apb_addr_w'(reg_res_base + 4 * i), data);
    check_value(test, $sformatf("lane %0d result", i), model_acc[i], data);
  end
  apb_read(test, reg_status, data);
  check_value(test, "status", 32'(model_ovf), data);
endtask

task automatic test_reset_values();
  model_clear();
  check_lanes("reset_values");
endtask

task automatic test_plain_accumulation();
  set_exp("plain_accumulation", 3'd0);
  clear_engine("plain_accumulation");
  set_weight("plain_accumulation", 8'd3);
  mac_beat("plain_accumulation", 32'h04FD7F01);
  set_weight("plain_accumulation", 8'hFB);
  mac_beat("plain_accumulation", 32'h801002FF);
  set_weight("plain_accumulation", 8'h7F);
  mac_beat("plain_accumulation", 32'h1122807F);
  check_lanes("plain_accumulation");
endtask

task automatic test_exponent_scaling();
  clear_engine("exponent_scaling");
  repeat (scale_rounds) begin
    set_exp("exponent_scaling", exp_w'($random(seed)));
    set_weight("exponent_scaling", elem_w'($random(seed)));
    // Two beats with no idle cycle between them
    mac_beat("exponent_scaling", $random(seed));
    mac_beat("exponent_scaling", $random(seed));
    check_lanes("exponent_scaling");
  end
endtask

task automatic test_overflow();
  logic [31:0] data;
  set_exp("overflow", 3'd7);
  set_weight("overflow", 8'h80);
  clear_engine("overflow");
  repeat (ovf_beats) begin
    mac_beat("overflow", 32'h7F7F7F7F);
  end
  check_lanes("overflow");
  apb_read("overflow", reg_status, data);
  check_value("overflow", "all status bits", 32'({num_lanes{1'b1}}), data);
  clear_engine("overflow");
  check_lanes("overflow");
endtask

task automatic test_clear_ordering();
  set_exp("clear_ordering", 3'd1);
  set_weight("clear_ordering", 8'd9);
  clear_engine("clear_ordering");
  mac_beat("clear_ordering", 32'h7F80017E);
  clear_engine("clear_ordering");
  mac_beat("clear_ordering", 32'h05FA3CC4);
  check_lanes("clear_ordering");
endtask

task automatic test_unmapped_access();
  logic [31:0] data;
  logic        err;
  set_weight("unmapped_access", 8'h5A);
  apb_access(1'b1, 8'h44, 32'hFFFFFFFF, data, err);
  check_value("unmapped_access", "pslverr on write 0x44", 32'd1, 32'(err));
  apb_access(1'b0, 8'h18, 32'd0, data, err);
  check_value("unmapped_access", "pslverr on read 0x18", 32'd1, 32'(err));
  check_value("unmapped_access", "read data 0x18", 32'd0, data);
  apb_read("unmapped_access", reg_welem, data);
  check_value("unmapped_access", "weight register", 32'h5A, data);
  apb_read("unmapped_access", reg_xexp, data);
  check_value("unmapped_access", "exponent register", 32'(model_exp), data);
  check_lanes("unmapped_access");
endtask

`endif

/* tests/redmule_tb.sv */
// Directed testbench for the MX vector engine, driven over APB.
// Inputs change 2 ns after the rising edge, outputs are sampled on the falling edge.
// The first failing check ends the run. A watchdog bounds the total run time.

`timescale 1ns/1ps

module redmule_tb;
  import redmule_pkg::*;

  localparam int unsigned num_lanes    = 4;
  localparam int unsigned clk_period   = 40;
  localparam int unsigned drive_delay  = 2;
  localparam int unsigned reset_cycles = 5;

  // Test lengths
  localparam int unsigned scale_rounds = 8;
  localparam int unsigned ovf_beats    = 1040;
  localparam int unsigned lane_reads   = num_lanes + 1;

  // Upper bound on APB accesses over all tests, with slack for config writes
  localparam int unsigned access_budget =
    ovf_beats + scale_rounds * (4 + lane_reads) + 7 * lane_reads + 32;
  localparam int unsigned cycles_per_access = 10;
  localparam int unsigned watchdog_ns =
    (access_budget * cycles_per_access + reset_cycles + 4) * clk_period;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [apb_data_w-1:0] pwdata;
  logic [apb_data_w-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  integer seed;
  int     error_count;

  // Reference model state
  logic signed [acc_w-1:0] model_acc [num_lanes];
  logic [num_lanes-1:0]    model_ovf;
  logic [elem_w-1:0]       model_w;
  logic [exp_w-1:0]        model_exp;

  `include "redmule_tb_tasks.svh"

  redmule_top #(
    .num_lanes ( num_lanes )
  ) u_dut (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .prdata_o  ( prdata  ),
    .pready_o  ( pready  ),
    .pslverr_o ( pslverr )
  );

  initial begin
    clk = 1'b0;
  end

  always #(clk_period / 2) clk = ~clk;

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed        = 32'h0ccd9fc2;
    error_count = 0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    model_w     = '0;
    model_exp   = '0;
    model_clear();

    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;
    @(posedge clk);
    #(drive_delay);

    test_reset_values();
    test_plain_accumulation();
    test_exponent_scaling();
    test_overflow();
    test_clear_ordering();
    test_unmapped_access();

    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : redmule_tb

/* files.f */
+incdir+tests
common/redmule_pkg.sv
engine/redmule_pe.sv
engine/redmule_z_collector.sv
hdl/redmule_mx_decoder.sv
hdl/redmule_apb_regs.sv
hdl/redmule_top.sv
tests/redmule_tb.sv

/* Makefile */
# Verilator build and run for the MX vector engine testbench

VERILATOR ?= verilator
TOP       ?= redmule_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# Build, run and decide the verdict from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
